//--- source/afu_settings.svh
`ifndef AFU_SETTINGS_SVH
`define AFU_SETTINGS_SVH

// ======================================================================
// Datapath widths
// ======================================================================

// One data word, also the width of every MMIO register
`define AFU_DATA_W 32

// Virtual addresses and host word addresses share this width
`define AFU_VADDR_W 32

// Upper bits of a virtual address select one of four segments
`define AFU_SEG_W 2

// ======================================================================
// MMIO register map
// ======================================================================

// Register index width on the MMIO bus
`define AFU_MMIO_ADDR_W 4

// Segment base addresses, in host words
`define AFU_REG_BASE0 4'd0
`define AFU_REG_BASE1 4'd1
`define AFU_REG_BASE2 4'd2
`define AFU_REG_BASE3 4'd3

// Number of words to copy from segment 0 to segment 1
`define AFU_REG_COUNT 4'd4

// Writing 1 here starts a run, reads return zero
`define AFU_REG_GO 4'd5

// Read only status and checksum
`define AFU_REG_DONE 4'd6
`define AFU_REG_SUM 4'd7

`endif

//--- source/afu_pkg.sv
`include "afu_settings.svh"

package afu_pkg;

   // ===================================================================
   // Processor memory operations
   // ===================================================================

   // Anything other than op_idle is a live request on the four-phase
   // handshake between the processor and the memory controller
   typedef enum logic [1:0] {
      op_idle  = 2'd0,
      op_read  = 2'd1,
      op_write = 2'd2
   } mem_op_t;

   // ===================================================================
   // Virtual address word
   // ===================================================================

   // The processor builds the address as one flat word, while the
   // translation unit needs the segment and the offset separately.
   // Both views cover the same bits, so a packed union keeps them
   // in step without any shifting or masking on either side
   typedef union packed {
      // Flat word as the processor sees it
      logic [`AFU_VADDR_W-1:0] flat;

      // Segment in the top bits, word offset below it
      struct packed {
         logic [`AFU_SEG_W-1:0]              seg;
         logic [`AFU_VADDR_W-`AFU_SEG_W-1:0] offset;
      } split;
   } vaddr_u;

endpackage

//--- source/memory_map.sv
`include "afu_settings.svh"

module memory_map (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        mmio_wr_en,
   input  logic                        mmio_rd_en,
   input  logic [`AFU_MMIO_ADDR_W-1:0] mmio_addr,
   input  logic [`AFU_DATA_W-1:0]      mmio_wr_data,
   output logic [`AFU_DATA_W-1:0]      mmio_rd_data,
   output logic                        mmio_rd_valid,
   output logic [`AFU_VADDR_W-1:0]     base0,
   output logic [`AFU_VADDR_W-1:0]     base1,
   output logic [`AFU_VADDR_W-1:0]     base2,
   output logic [`AFU_VADDR_W-1:0]     base3,
   output logic [`AFU_DATA_W-1:0]      count,
   output logic                        go,
   input  logic                        done_in,
   input  logic [`AFU_DATA_W-1:0]      sum
);

   // Sticky completion flag seen by software
   logic done_q;

   // A write of 1 to the go register starts a run
   logic go_wr;

   assign go_wr = mmio_wr_en && (mmio_addr == `AFU_REG_GO) && mmio_wr_data[0];

   // ===================================================================
   // Software writable registers
   // ===================================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         base0  <= '0;
         base1  <= '0;
         base2  <= '0;
         base3  <= '0;
         count  <= '0;
         go     <= 1'b0;
         done_q <= 1'b0;
      end else begin
         // The go register never holds a value, it only fires for one cycle
         go <= go_wr;

         if (mmio_wr_en) begin
            case (mmio_addr)
               `AFU_REG_BASE0: base0 <= mmio_wr_data;
               `AFU_REG_BASE1: base1 <= mmio_wr_data;
               `AFU_REG_BASE2: base2 <= mmio_wr_data;
               `AFU_REG_BASE3: base3 <= mmio_wr_data;
               `AFU_REG_COUNT: count <= mmio_wr_data;
               default: ;
            endcase
         end

         // A new run clears the old status before the processor starts,
         // so software never sees a stale done for the new run
         if (go_wr) begin
            done_q <= 1'b0;
         end else if (done_in) begin
            done_q <= 1'b1;
         end
      end
   end

   // ===================================================================
   // Read path
   // ===================================================================

   // The valid strobe follows the request by exactly one cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mmio_rd_valid <= 1'b0;
      end else begin
         mmio_rd_valid <= mmio_rd_en;
      end
   end

   // Read data only matters while the strobe is high
   always_ff @(posedge clk) begin
      if (mmio_rd_en) begin
         case (mmio_addr)
            `AFU_REG_BASE0: mmio_rd_data <= base0;
            `AFU_REG_BASE1: mmio_rd_data <= base1;
            `AFU_REG_BASE2: mmio_rd_data <= base2;
            `AFU_REG_BASE3: mmio_rd_data <= base3;
            `AFU_REG_COUNT: mmio_rd_data <= count;
            `AFU_REG_DONE:  mmio_rd_data <= {{(`AFU_DATA_W-1){1'b0}}, done_q};
            `AFU_REG_SUM:   mmio_rd_data <= sum;
            // Go and unmapped indices read as zero
            default:        mmio_rd_data <= '0;
         endcase
      end
   end

endmodule

//--- source/cpu.sv
`include "afu_settings.svh"

module cpu (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   go,
   input  logic [`AFU_DATA_W-1:0] count,
   output afu_pkg::mem_op_t       op,
   output afu_pkg::vaddr_u        cpu_addr,
   output logic [`AFU_DATA_W-1:0] cpu_wdata,
   input  logic [`AFU_DATA_W-1:0] cpu_rdata,
   input  logic                   rd_valid,
   input  logic                   tx_done,
   output logic                   done_out,
   output logic [`AFU_DATA_W-1:0] sum
);

   localparam int OFF_W = `AFU_VADDR_W - `AFU_SEG_W;

   // Every request state has a matching release state where op is back
   // at idle and the FSM waits for tx_done to fall
   localparam logic [3:0] S_IDLE    = 4'd0;
   localparam logic [3:0] S_RD      = 4'd1;
   localparam logic [3:0] S_RD_REL  = 4'd2;
   localparam logic [3:0] S_WR      = 4'd3;
   localparam logic [3:0] S_WR_REL  = 4'd4;
   localparam logic [3:0] S_SUM_WR  = 4'd5;
   localparam logic [3:0] S_SUM_REL = 4'd6;
   localparam logic [3:0] S_CNT_WR  = 4'd7;
   localparam logic [3:0] S_CNT_REL = 4'd8;

   logic [3:0]             state;
   logic [`AFU_DATA_W-1:0] idx;
   logic [`AFU_DATA_W-1:0] idx_next;
   logic [`AFU_DATA_W-1:0] word_q;
   logic [`AFU_SEG_W-1:0]  seg_sel;
   logic [OFF_W-1:0]       off_sel;

   assign idx_next = idx + 1'b1;

   // ===================================================================
   // Request outputs, decoded from the state
   // ===================================================================

   always_comb begin
      op        = afu_pkg::op_idle;
      seg_sel   = 2'd0;
      off_sel   = '0;
      cpu_wdata = '0;
      case (state)
         S_RD: begin
            op      = afu_pkg::op_read;
            off_sel = idx[OFF_W-1:0];
         end
         S_WR: begin
            // Same offset as the read, one segment up
            op        = afu_pkg::op_write;
            seg_sel   = 2'd1;
            off_sel   = idx[OFF_W-1:0];
            cpu_wdata = word_q;
         end
         S_SUM_WR: begin
            op        = afu_pkg::op_write;
            seg_sel   = 2'd2;
            cpu_wdata = sum;
         end
         S_CNT_WR: begin
            op        = afu_pkg::op_write;
            seg_sel   = 2'd3;
            cpu_wdata = count;
         end
         default: ;
      endcase
      // The processor only knows flat addresses with the segment on top
      cpu_addr.flat = {seg_sel, off_sel};
   end

   // ===================================================================
   // Sequencer
   // ===================================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= S_IDLE;
         idx      <= '0;
         sum      <= '0;
         done_out <= 1'b0;
      end else begin
         done_out <= 1'b0;
         case (state)
            S_IDLE: if (go) begin
               idx   <= '0;
               sum   <= '0;
               // An empty copy goes straight to the result writes
               state <= (count == '0) ? S_SUM_WR : S_RD;
            end
            S_RD: if (tx_done && rd_valid) begin
               // Sum wraps modulo 2^32 like the software reference
               sum   <= sum + cpu_rdata;
               state <= S_RD_REL;
            end
            S_RD_REL:  if (!tx_done) state <= S_WR;
            S_WR:      if (tx_done) state <= S_WR_REL;
            S_WR_REL: if (!tx_done) begin
               idx   <= idx_next;
               state <= (idx_next == count) ? S_SUM_WR : S_RD;
            end
            S_SUM_WR:  if (tx_done) state <= S_SUM_REL;
            S_SUM_REL: if (!tx_done) state <= S_CNT_WR;
            S_CNT_WR:  if (tx_done) state <= S_CNT_REL;
            S_CNT_REL: if (!tx_done) begin
               done_out <= 1'b1;
               state    <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Copy word, held for the write that follows the read
   always_ff @(posedge clk) begin
      if (state == S_RD && tx_done && rd_valid) begin
         word_q <= cpu_rdata;
      end
   end

endmodule

//--- source/addr_tr_unit.sv
`include "afu_settings.svh"

module addr_tr_unit (
   input  afu_pkg::vaddr_u         cpu_addr,
   input  logic [`AFU_VADDR_W-1:0] base0,
   input  logic [`AFU_VADDR_W-1:0] base1,
   input  logic [`AFU_VADDR_W-1:0] base2,
   input  logic [`AFU_VADDR_W-1:0] base3,
   output logic [`AFU_VADDR_W-1:0] host_addr
);

   // Base of the segment named in the top bits of the virtual address
   logic [`AFU_VADDR_W-1:0] base_sel;

   // ===================================================================
   // Segment lookup
   // ===================================================================

   // Pure combinational path, the host address follows cpu_addr in the
   // same cycle so the memory controller can register it on the request
   always_comb begin
      case (cpu_addr.split.seg)
         2'd0:    base_sel = base0;
         2'd1:    base_sel = base1;
         2'd2:    base_sel = base2;
         default: base_sel = base3;
      endcase

      // Offset is in words, zero extended over the segment bits
      host_addr = base_sel + {{`AFU_SEG_W{1'b0}}, cpu_addr.split.offset};
   end

endmodule

//--- source/mem_ctrl.sv
`include "afu_settings.svh"

module mem_ctrl (
   input  logic                    clk,
   input  logic                    rst_n,
   input  afu_pkg::mem_op_t        op,
   input  logic [`AFU_VADDR_W-1:0] host_addr,
   input  logic [`AFU_DATA_W-1:0]  cpu_wdata,
   output logic [`AFU_DATA_W-1:0]  cpu_rdata,
   output logic                    rd_valid,
   output logic                    tx_done,
   output logic                    rd_go,
   output logic [`AFU_VADDR_W-1:0] rd_addr,
   output logic                    rd_en,
   input  logic [`AFU_DATA_W-1:0]  rd_data,
   input  logic                    empty,
   output logic                    wr_go,
   output logic [`AFU_VADDR_W-1:0] wr_addr,
   output logic                    wr_en,
   output logic [`AFU_DATA_W-1:0]  wr_data,
   input  logic                    full,
   input  logic                    wr_done
);

   localparam logic [2:0] S_IDLE    = 3'd0;
   localparam logic [2:0] S_RD_WAIT = 3'd1;
   localparam logic [2:0] S_WR_WAIT = 3'd2;
   localparam logic [2:0] S_WR_DONE = 3'd3;
   localparam logic [2:0] S_ACK     = 3'd4;

   logic [2:0]              state;
   logic [`AFU_VADDR_W-1:0] addr_q;
   logic [`AFU_DATA_W-1:0]  data_q;
   logic [`AFU_DATA_W-1:0]  rdata_q;

   // Both DMA channels see the address captured at the request
   assign rd_addr   = addr_q;
   assign wr_addr   = addr_q;
   assign wr_data   = data_q;
   assign cpu_rdata = rdata_q;

   // ===================================================================
   // Transfer FSM
   // ===================================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= S_IDLE;
         rd_go    <= 1'b0;
         wr_go    <= 1'b0;
         rd_en    <= 1'b0;
         wr_en    <= 1'b0;
         tx_done  <= 1'b0;
         rd_valid <= 1'b0;
      end else begin
         // Go and enable strobes last one cycle unless set again below
         rd_go <= 1'b0;
         wr_go <= 1'b0;
         rd_en <= 1'b0;
         wr_en <= 1'b0;
         case (state)
            S_IDLE: begin
               if (op == afu_pkg::op_read) begin
                  rd_go <= 1'b1;
                  state <= S_RD_WAIT;
               end else if (op == afu_pkg::op_write) begin
                  wr_go <= 1'b1;
                  state <= S_WR_WAIT;
               end
            end
            // Stall here while the host has nothing for us
            S_RD_WAIT: if (!empty) begin
               rd_en    <= 1'b1;
               tx_done  <= 1'b1;
               rd_valid <= 1'b1;
               state    <= S_ACK;
            end
            // Stall here while the host write buffer is full
            S_WR_WAIT: if (!full) begin
               wr_en <= 1'b1;
               state <= S_WR_DONE;
            end
            // The word is only acknowledged once the host has committed it
            S_WR_DONE: if (wr_done) begin
               tx_done <= 1'b1;
               state   <= S_ACK;
            end
            // Last phase of the handshake, wait for the processor to let go
            S_ACK: if (op == afu_pkg::op_idle) begin
               tx_done  <= 1'b0;
               rd_valid <= 1'b0;
               state    <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // ===================================================================
   // Transfer payload
   // ===================================================================

   // Address and write data are frozen at the request so the processor
   // side may change while the DMA waits
   always_ff @(posedge clk) begin
      if (state == S_IDLE && op != afu_pkg::op_idle) begin
         addr_q <= host_addr;
         data_q <= cpu_wdata;
      end
      // The host shows the word ahead of rd_en, take it with the pop
      if (state == S_RD_WAIT && !empty) begin
         rdata_q <= rd_data;
      end
   end

endmodule

//--- source/afu.sv
`include "afu_settings.svh"

module afu (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        mmio_wr_en,
   input  logic                        mmio_rd_en,
   input  logic [`AFU_MMIO_ADDR_W-1:0] mmio_addr,
   input  logic [`AFU_DATA_W-1:0]      mmio_wr_data,
   output logic [`AFU_DATA_W-1:0]      mmio_rd_data,
   output logic                        mmio_rd_valid,
   output logic                        rd_go,
   output logic [`AFU_VADDR_W-1:0]     rd_addr,
   output logic                        rd_en,
   input  logic [`AFU_DATA_W-1:0]      rd_data,
   input  logic                        empty,
   output logic                        wr_go,
   output logic [`AFU_VADDR_W-1:0]     wr_addr,
   output logic                        wr_en,
   output logic [`AFU_DATA_W-1:0]      wr_data,
   input  logic                        full,
   input  logic                        wr_done
);

   // Software programmed configuration
   logic [`AFU_VADDR_W-1:0] base0;
   logic [`AFU_VADDR_W-1:0] base1;
   logic [`AFU_VADDR_W-1:0] base2;
   logic [`AFU_VADDR_W-1:0] base3;
   logic [`AFU_DATA_W-1:0]  count;
   logic                    go;
   logic                    done;
   logic [`AFU_DATA_W-1:0]  sum;

   // Processor side of the four-phase handshake
   afu_pkg::mem_op_t        op;
   afu_pkg::vaddr_u         cpu_addr;
   logic [`AFU_DATA_W-1:0]  cpu_wdata;
   logic [`AFU_DATA_W-1:0]  cpu_rdata;
   logic                    rd_valid;
   logic                    tx_done;
   logic [`AFU_VADDR_W-1:0] host_addr;

   // ===================================================================
   // Control and status registers
   // ===================================================================

   memory_map u_memory_map (
      .clk(clk), .rst_n(rst_n),
      .mmio_wr_en(mmio_wr_en), .mmio_rd_en(mmio_rd_en),
      .mmio_addr(mmio_addr), .mmio_wr_data(mmio_wr_data),
      .mmio_rd_data(mmio_rd_data), .mmio_rd_valid(mmio_rd_valid),
      .base0(base0), .base1(base1), .base2(base2), .base3(base3),
      .count(count), .go(go), .done_in(done), .sum(sum)
   );

   // ===================================================================
   // Processor, translation and host access
   // ===================================================================

   cpu u_cpu (
      .clk(clk), .rst_n(rst_n), .go(go), .count(count),
      .op(op), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
      .cpu_rdata(cpu_rdata), .rd_valid(rd_valid), .tx_done(tx_done),
      .done_out(done), .sum(sum)
   );

   addr_tr_unit u_addr_tr_unit (
      .cpu_addr(cpu_addr),
      .base0(base0), .base1(base1), .base2(base2), .base3(base3),
      .host_addr(host_addr)
   );

   mem_ctrl u_mem_ctrl (
      .clk(clk), .rst_n(rst_n), .op(op), .host_addr(host_addr),
      .cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata),
      .rd_valid(rd_valid), .tx_done(tx_done),
      .rd_go(rd_go), .rd_addr(rd_addr), .rd_en(rd_en),
      .rd_data(rd_data), .empty(empty),
      .wr_go(wr_go), .wr_addr(wr_addr), .wr_en(wr_en),
      .wr_data(wr_data), .full(full), .wr_done(wr_done)
   );

endmodule

//--- bench/afu_checker.sv
`include "afu_settings.svh"

module afu_checker (
   input logic                     clk,
   input logic                     rst_n,
   input logic                     rd_go,
   input logic [`AFU_VADDR_W-1:0]  rd_addr,
   input logic                     wr_en,
   input logic [`AFU_VADDR_W-1:0]  wr_addr,
   input logic [`AFU_DATA_W-1:0]   wr_data,
   input logic                     mmio_rd_en,
   input logic                     mmio_rd_valid,
   input logic [`AFU_DATA_W-1:0]   mmio_rd_data
);
   timeunit 1ns;
   timeprecision 1ns;

   int    errors = 0;
   string test_name = "reset";

   // Expected DMA traffic and MMIO answers with the oldest at the front
   logic [`AFU_VADDR_W-1:0] exp_rd_addr [$];
   logic [`AFU_VADDR_W-1:0] exp_wr_addr [$];
   logic [`AFU_DATA_W-1:0]  exp_wr_data [$];
   bit                      exp_wr_copy [$];
   logic [`AFU_DATA_W-1:0]  exp_mmio [$];
   string                   exp_mmio_label [$];

   // Reads seen that no copy write has consumed yet
   int   reads_ahead = 0;
   logic rd_req_q = 1'b0;

   task automatic set_test(input string name);
      test_name   = name;
      reads_ahead = 0;
   endtask

   task automatic expect_read(input logic [`AFU_VADDR_W-1:0] addr);
      exp_rd_addr.push_back(addr);
   endtask

   // A copy write must follow a read of the same index
   task automatic expect_write(input logic [`AFU_VADDR_W-1:0] addr,
                               input logic [`AFU_DATA_W-1:0] data, input bit copy);
      exp_wr_addr.push_back(addr);
      exp_wr_data.push_back(data);
      exp_wr_copy.push_back(copy);
   endtask

   task automatic expect_mmio(input string label, input logic [`AFU_DATA_W-1:0] value);
      exp_mmio_label.push_back(label);
      exp_mmio.push_back(value);
   endtask

   task automatic compare(input string label, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED test %s %s: expected %h, actual %h", test_name, label, exp, act);
      end
   endtask

   task automatic report_problem(input string what);
      errors++;
      $display("Error in test %s: %s", test_name, what);
   endtask

   // Anything still queued after done never reached the host
   task automatic check_drained();
      if (exp_wr_addr.size() != 0) begin
         report_problem($sformatf("%0d DMA writes never arrived", exp_wr_addr.size()));
      end
      if (exp_rd_addr.size() != 0) begin
         report_problem($sformatf("%0d DMA reads never arrived", exp_rd_addr.size()));
      end
      exp_wr_addr.delete();
      exp_wr_data.delete();
      exp_wr_copy.delete();
      exp_rd_addr.delete();
   endtask

   // ====================================================================
   // Monitors
   // ====================================================================

   // The MMIO request is driven on the falling edge, so take it on the rising one
   always @(posedge clk) begin
      rd_req_q <= rst_n && mmio_rd_en;
   end

   always @(negedge clk) begin
      if (rst_n) begin
         if (rd_go) begin
            reads_ahead++;
            if (exp_rd_addr.size() == 0) begin
               report_problem($sformatf("unexpected DMA read of address %h", rd_addr));
            end else begin
               compare("DMA read address", exp_rd_addr.pop_front(), rd_addr);
            end
         end
         if (wr_en) begin
            if (exp_wr_addr.size() == 0) begin
               report_problem($sformatf("unexpected DMA write to address %h", wr_addr));
            end else begin
               if (exp_wr_copy.pop_front()) begin
                  if (reads_ahead == 0) begin
                     report_problem("copy write arrived without a read before it");
                  end else begin
                     reads_ahead--;
                  end
               end
               compare("DMA write address", exp_wr_addr.pop_front(), wr_addr);
               compare("DMA write data", exp_wr_data.pop_front(), wr_data);
            end
         end
         // Valid has to show up exactly one cycle after the request
         if (rd_req_q && !mmio_rd_valid) begin
            report_problem("MMIO read response missing one cycle after the request");
         end else if (!rd_req_q && mmio_rd_valid) begin
            report_problem("MMIO read response without a request");
         end else if (mmio_rd_valid) begin
            if (exp_mmio.size() == 0) begin
               report_problem("MMIO read response with no expected value");
            end else begin
               compare(exp_mmio_label.pop_front(), exp_mmio.pop_front(), mmio_rd_data);
            end
         end
      end
   end

endmodule

//--- bench/afu_tb.sv
`include "afu_settings.svh"

module afu_tb;
   timeunit 1ns;
   timeprecision 1ns;

   localparam int NUM_CASES    = 4;
   localparam int DONE_TIMEOUT = 5000;

   logic                        clk = 1'b0;
   logic                        rst_n = 1'b0;
   logic                        mmio_wr_en = 1'b0;
   logic                        mmio_rd_en = 1'b0;
   logic [`AFU_MMIO_ADDR_W-1:0] mmio_addr = '0;
   logic [`AFU_DATA_W-1:0]      mmio_wr_data = '0;
   logic [`AFU_DATA_W-1:0]      mmio_rd_data;
   logic                        mmio_rd_valid;
   logic                        rd_go;
   logic [`AFU_VADDR_W-1:0]     rd_addr;
   logic                        rd_en;
   logic [`AFU_DATA_W-1:0]      rd_data = '0;
   logic                        empty = 1'b1;
   logic                        wr_go;
   logic [`AFU_VADDR_W-1:0]     wr_addr;
   logic                        wr_en;
   logic [`AFU_DATA_W-1:0]      wr_data;
   logic                        full = 1'b1;
   logic                        wr_done = 1'b0;

   // Host memory indexed by the low byte of the host word address
   logic [31:0] host_mem [256];
   logic [31:0] rng_state = 32'hd1db5ee3;
   bit          heavy = 1'b0;

   // DMA model state for each channel
   logic [7:0] rd_ptr = '0;
   int         rd_stall = 0;
   bit         rd_busy = 1'b0;
   int         wr_stall = 0;
   bit         wr_busy = 1'b0;

   string case_name [NUM_CASES] = '{"basic", "stalls", "zero_count", "long_stalls"};

   // Each row holds base0, base1, base2, base3, the count and the heavy stall flag
   logic [31:0] case_cfg [NUM_CASES][6] = '{
      '{32'h10, 32'h40, 32'h80, 32'h81, 32'd8,  32'd0},
      '{32'h20, 32'h60, 32'h90, 32'h91, 32'd12, 32'd1},
      '{32'h00, 32'h30, 32'ha0, 32'ha1, 32'd0,  32'd0},
      '{32'hb0, 32'hc8, 32'hf0, 32'hf8, 32'd20, 32'd1}
   };

   afu u_afu (
      .clk(clk), .rst_n(rst_n),
      .mmio_wr_en(mmio_wr_en), .mmio_rd_en(mmio_rd_en),
      .mmio_addr(mmio_addr), .mmio_wr_data(mmio_wr_data),
      .mmio_rd_data(mmio_rd_data), .mmio_rd_valid(mmio_rd_valid),
      .rd_go(rd_go), .rd_addr(rd_addr), .rd_en(rd_en), .rd_data(rd_data), .empty(empty),
      .wr_go(wr_go), .wr_addr(wr_addr), .wr_en(wr_en), .wr_data(wr_data),
      .full(full), .wr_done(wr_done)
   );

   afu_checker u_checker (
      .clk(clk), .rst_n(rst_n), .rd_go(rd_go), .rd_addr(rd_addr),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
      .mmio_rd_en(mmio_rd_en), .mmio_rd_valid(mmio_rd_valid), .mmio_rd_data(mmio_rd_data)
   );

   initial begin
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Heavy cases hold the channel off for up to five cycles
   function automatic int stall_cycles();
      return heavy ? int'(next_rand() % 6) : int'(next_rand() % 2);
   endfunction

   // ====================================================================
   // Host DMA model driven on the falling edge
   // ====================================================================

   always @(negedge clk) begin
      if (rd_go) begin
         rd_ptr   = rd_addr[7:0];
         rd_stall = stall_cycles();
         rd_busy  = 1'b1;
         empty    = 1'b1;
      end else if (rd_en) begin
         rd_busy = 1'b0;
         empty   = 1'b1;
      end else if (rd_busy && rd_stall > 0) begin
         rd_stall--;
      end else if (rd_busy) begin
         rd_data = host_mem[rd_ptr];
         empty   = 1'b0;
      end
      // The write side keeps wr_done up until the next transfer starts
      if (wr_go) begin
         wr_stall = stall_cycles();
         wr_busy  = 1'b1;
         wr_done  = 1'b0;
         full     = 1'b1;
      end else if (wr_en) begin
         host_mem[wr_addr[7:0]] = wr_data;
         wr_busy = 1'b0;
         wr_done = 1'b1;
         full    = 1'b1;
      end else if (wr_busy && wr_stall > 0) begin
         wr_stall--;
      end else if (wr_busy) begin
         full = 1'b0;
      end
   end

   // Both MMIO tasks start and end on a falling edge
   task automatic mmio_write(input logic [`AFU_MMIO_ADDR_W-1:0] addr,
                             input logic [`AFU_DATA_W-1:0] data);
      mmio_wr_en   = 1'b1;
      mmio_addr    = addr;
      mmio_wr_data = data;
      @(negedge clk);
      mmio_wr_en = 1'b0;
   endtask

   task automatic mmio_read(input string label, input logic [`AFU_MMIO_ADDR_W-1:0] addr,
                            input logic [`AFU_DATA_W-1:0] exp);
      u_checker.expect_mmio(label, exp);
      mmio_rd_en = 1'b1;
      mmio_addr  = addr;
      @(negedge clk);
      mmio_rd_en = 1'b0;
   endtask

   // ====================================================================
   // Test sequence
   // ====================================================================

   initial begin
      int          timeouts;
      int          cycles;
      logic [31:0] exp_sum;
      logic [31:0] src;
      timeouts = 0;
      for (int a = 0; a < 256; a++) begin
         host_mem[a] = next_rand() ^ a;
      end
      repeat (4) @(negedge clk);
      rst_n = 1'b1;

      // Quiet outputs and a clear done flag straight out of reset
      u_checker.compare("rd_go", 32'd0, 32'(rd_go));
      u_checker.compare("wr_go", 32'd0, 32'(wr_go));
      u_checker.compare("rd_en", 32'd0, 32'(rd_en));
      u_checker.compare("wr_en", 32'd0, 32'(wr_en));
      u_checker.compare("mmio_rd_valid", 32'd0, 32'(mmio_rd_valid));
      mmio_read("done after reset", `AFU_REG_DONE, 32'd0);

      for (int c = 0; c < NUM_CASES && timeouts == 0; c++) begin
         u_checker.set_test(case_name[c]);
         heavy = case_cfg[c][5][0];
         // Table columns 0 to 4 line up with register indices 0 to 4
         for (int j = 0; j < 5; j++) begin
            mmio_write(j[`AFU_MMIO_ADDR_W-1:0], case_cfg[c][j]);
         end
         for (int j = 0; j < 5; j++) begin
            mmio_read($sformatf("register %0d readback", j), j[`AFU_MMIO_ADDR_W-1:0],
                      case_cfg[c][j]);
         end

         // Expected traffic comes from the host memory as it is before the run
         exp_sum = '0;
         for (int i = 0; i < int'(case_cfg[c][4]); i++) begin
            src = case_cfg[c][0] + 32'(i);
            u_checker.expect_read(src);
            u_checker.expect_write(case_cfg[c][1] + 32'(i), host_mem[src[7:0]], 1'b1);
            exp_sum = exp_sum + host_mem[src[7:0]];
         end
         u_checker.expect_write(case_cfg[c][2], exp_sum, 1'b0);
         u_checker.expect_write(case_cfg[c][3], case_cfg[c][4], 1'b0);

         mmio_write(`AFU_REG_GO, 32'd1);
         mmio_read("done cleared by go", `AFU_REG_DONE, 32'd0);

         cycles = 0;
         while (u_afu.u_memory_map.done_q !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
         end
         if (u_afu.u_memory_map.done_q !== 1'b1) begin
            $display("Timeout: test %s never set the done flag", case_name[c]);
            timeouts++;
         end else begin
            mmio_read("done flag", `AFU_REG_DONE, 32'd1);
            mmio_read("checksum", `AFU_REG_SUM, exp_sum);
            // One more edge so the checker takes the checksum answer under this test name
            @(negedge clk);
            u_checker.check_drained();
         end
      end

      $display("Closing report: %0d check errors, %0d timeouts", u_checker.errors, timeouts);
      if (u_checker.errors == 0 && timeouts == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- src.f
+incdir+source
source/afu_pkg.sv
source/memory_map.sv
source/cpu.sv
source/addr_tr_unit.sv
source/mem_ctrl.sv
source/afu.sv
bench/afu_checker.sv
bench/afu_tb.sv

//--- run.sh
#!/bin/sh
# Build the AFU testbench with Verilator, run it and judge the result from its output

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator was not found on the PATH"
   exit 1
fi

if ! verilator --binary --timing -Wno-fatal -f src.f --top-module afu_tb -o afu_sim; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/afu_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
   exit 0
fi
exit 1
